/* logic/tile_io_pkg.sv */
/*
  Shared definitions for the tile I/O complex
  - data and address widths
  - memory map: DRAM base, device codes, register offsets
  - address union, message, configuration bus and sink index types
*/
`default_nettype none

package tile_io_pkg;

  localparam int paddr_width_c   = 32;
  localparam int data_width_c    = 64;
  localparam int tile_width_c    = 8;
  localparam int dev_width_c     = 4;
  localparam int offset_width_c  = 20;
  localparam int core_id_width_c = 6;
  localparam int did_width_c     = 3;
  localparam int num_sinks_c     = 4;

  // Everything below this is local to the tile
  localparam logic [paddr_width_c-1:0] dram_base_c = 32'h8000_0000;

  localparam logic [dev_width_c-1:0] dev_cfg_c   = 4'd2;
  localparam logic [dev_width_c-1:0] dev_clint_c = 4'd3;
  localparam logic [dev_width_c-1:0] dev_cache_c = 4'd4;

  localparam logic [offset_width_c-1:0] cfg_freeze_offset_c   = 20'h0_0008;
  localparam logic [offset_width_c-1:0] cfg_core_id_offset_c  = 20'h0_0010;
  localparam logic [offset_width_c-1:0] cfg_host_did_offset_c = 20'h0_0018;

  localparam logic [offset_width_c-1:0] clint_msip_offset_c     = 20'h0_0000;
  localparam logic [offset_width_c-1:0] clint_mtimecmp_offset_c = 20'h0_4000;
  localparam logic [offset_width_c-1:0] clint_plic_offset_c     = 20'h0_B000;
  localparam logic [offset_width_c-1:0] clint_mtime_offset_c    = 20'h0_BFF8;

  typedef enum logic [1:0] {
    msg_read  = 2'b00,
    msg_write = 2'b01
  } msg_type_e;

  typedef struct packed {
    logic [tile_width_c-1:0]   tile;
    logic [dev_width_c-1:0]    dev;
    logic [offset_width_c-1:0] offset;
  } local_addr_s;

  // Same word seen flat or split into tile/device/offset
  typedef union packed {
    logic [paddr_width_c-1:0] paddr;
    local_addr_s              fields;
  } addr_u;

  // Single-beat command or response
  typedef struct packed {
    msg_type_e                msg_type;
    addr_u                    addr;
    logic [data_width_c-1:0]  data;
  } mem_msg_s;

  typedef struct packed {
    logic                       freeze;
    logic [core_id_width_c-1:0] core_id;
    logic [did_width_c-1:0]     host_did;
  } cfg_bus_s;

  // Dispatch order, also the response priority order
  typedef enum logic [1:0] {
    sink_mem      = 2'd0,
    sink_cfg      = 2'd1,
    sink_clint    = 2'd2,
    sink_loopback = 2'd3
  } sink_e;

endpackage

`default_nettype wire

/* logic/tile_io_decode.sv */
/*
  Command address decoder
  - DRAM and cache device addresses go to the memory port
  - cfg and CLINT device codes go to their blocks
  - other local device codes go to loopback
*/
`timescale 1ns/1ps
`default_nettype none

module tile_io_decode
  import tile_io_pkg::*;
(
  input  mem_msg_s               cmd_i,
  input  logic                   cmd_v_i,
  output logic                   cmd_ready_o,
  output logic [num_sinks_c-1:0] sink_v_o,
  input  logic [num_sinks_c-1:0] sink_ready_i
);

  addr_u addr;
  logic  is_local;
  logic  is_mem;
  sink_e sink_sel;

  assign addr     = cmd_i.addr;
  assign is_local = (addr.paddr < dram_base_c);
  assign is_mem   = !is_local || (addr.fields.dev == dev_cache_c);

  always_comb
  begin
    if (is_mem)
      sink_sel = sink_mem;
    else if (addr.fields.dev == dev_cfg_c)
      sink_sel = sink_cfg;
    else if (addr.fields.dev == dev_clint_c)
      sink_sel = sink_clint;
    else
      sink_sel = sink_loopback;
  end

  // Each sink matches its own address range, ready of the selected sink comes back
  assign sink_v_o[sink_mem]      = cmd_v_i & is_mem;
  assign sink_v_o[sink_cfg]      = cmd_v_i & !is_mem & (addr.fields.dev == dev_cfg_c);
  assign sink_v_o[sink_clint]    = cmd_v_i & !is_mem & (addr.fields.dev == dev_clint_c);
  assign sink_v_o[sink_loopback] = cmd_v_i & is_local & (addr.fields.dev != dev_cfg_c) &
                                   (addr.fields.dev != dev_clint_c) &
                                   (addr.fields.dev != dev_cache_c);
  assign cmd_ready_o = sink_ready_i[sink_sel];

  always_comb
  begin
    sink_onehot_a: assert final ($onehot0(sink_v_o) && (!cmd_v_i || sink_v_o[sink_sel]))
      else $error("command valid does not go to exactly the selected sink");
  end

endmodule

`default_nettype wire

/* logic/tile_io_cfg.sv */
/*
  Configuration register block
  - freeze, core id and host did registers
  - single-entry response register
  - configuration bus output
*/
`timescale 1ns/1ps
`default_nettype none

module tile_io_cfg
  import tile_io_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  mem_msg_s cmd_i,
  input  logic     cmd_v_i,
  output logic     cmd_ready_o,
  output mem_msg_s resp_o,
  output logic     resp_v_o,
  input  logic     resp_ready_i,
  output cfg_bus_s cfg_bus_o
);

  cfg_bus_s                  cfg_r;
  mem_msg_s                  resp_r;
  logic                      resp_v_r;
  logic                      cmd_accept;
  logic                      is_write;
  logic [offset_width_c-1:0] offset;
  logic [data_width_c-1:0]   rd_data;

  assign cmd_ready_o = ~resp_v_r;
  assign cmd_accept  = cmd_v_i & cmd_ready_o;
  assign is_write    = (cmd_i.msg_type == msg_write);
  assign offset      = cmd_i.addr.fields.offset;

  always_comb
  begin
    case (offset)
      cfg_freeze_offset_c:   rd_data = data_width_c'(cfg_r.freeze);
      cfg_core_id_offset_c:  rd_data = data_width_c'(cfg_r.core_id);
      cfg_host_did_offset_c: rd_data = data_width_c'(cfg_r.host_did);
      default:               rd_data = '0;
    endcase
  end

  // Core starts frozen until the host releases it
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      cfg_r.freeze   <= 1'b1;
      cfg_r.core_id  <= '0;
      cfg_r.host_did <= '0;
    end
    else if (cmd_accept && is_write)
    begin
      case (offset)
        cfg_freeze_offset_c:   cfg_r.freeze   <= cmd_i.data[0];
        cfg_core_id_offset_c:  cfg_r.core_id  <= cmd_i.data[core_id_width_c-1:0];
        cfg_host_did_offset_c: cfg_r.host_did <= cmd_i.data[did_width_c-1:0];
        default:               ;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      resp_v_r <= 1'b0;
    else if (cmd_accept)
      resp_v_r <= 1'b1;
    else if (resp_ready_i)
      resp_v_r <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_accept)
    begin
      resp_r.msg_type <= cmd_i.msg_type;
      resp_r.addr     <= cmd_i.addr;
      resp_r.data     <= is_write ? '0 : rd_data;
    end
  end

  assign resp_o    = resp_r;
  assign resp_v_o  = resp_v_r;
  assign cfg_bus_o = cfg_r;

  single_pending_a: assert property (@(posedge clk_i) disable iff (reset_i)
    (resp_v_o && !resp_ready_i) |=> (resp_v_o && $stable(resp_o)))
    else $error("cfg changed or dropped a pending response");

endmodule

`default_nettype wire

/* logic/tile_io_clint.sv */
/*
  CLINT slice
  - msip, mtimecmp, mtime and external interrupt registers
  - free-running mtime counter
  - software, timer and external interrupt outputs
*/
`timescale 1ns/1ps
`default_nettype none

module tile_io_clint
  import tile_io_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  mem_msg_s cmd_i,
  input  logic     cmd_v_i,
  output logic     cmd_ready_o,
  output mem_msg_s resp_o,
  output logic     resp_v_o,
  input  logic     resp_ready_i,
  output logic     software_irq_o,
  output logic     timer_irq_o,
  output logic     external_irq_o
);

  logic                      msip_r;
  logic                      plic_r;
  logic [data_width_c-1:0]   mtimecmp_r;
  logic [data_width_c-1:0]   mtime_r;
  mem_msg_s                  resp_r;
  logic                      resp_v_r;
  logic                      cmd_accept;
  logic                      wr_en;
  logic [offset_width_c-1:0] offset;
  logic [data_width_c-1:0]   rd_data;

  assign cmd_ready_o = ~resp_v_r;
  assign cmd_accept  = cmd_v_i & cmd_ready_o;
  assign wr_en       = cmd_accept & (cmd_i.msg_type == msg_write);
  assign offset      = cmd_i.addr.fields.offset;

  always_comb
  begin
    case (offset)
      clint_msip_offset_c:     rd_data = data_width_c'(msip_r);
      clint_mtimecmp_offset_c: rd_data = mtimecmp_r;
      clint_plic_offset_c:     rd_data = data_width_c'(plic_r);
      clint_mtime_offset_c:    rd_data = mtime_r;
      default:                 rd_data = '0;
    endcase
  end

  // Compare value of all ones keeps the timer quiet after reset
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      msip_r     <= 1'b0;
      plic_r     <= 1'b0;
      mtimecmp_r <= '1;
    end
    else if (wr_en)
    begin
      case (offset)
        clint_msip_offset_c:     msip_r     <= cmd_i.data[0];
        clint_mtimecmp_offset_c: mtimecmp_r <= cmd_i.data;
        clint_plic_offset_c:     plic_r     <= cmd_i.data[0];
        default:                 ;
      endcase
    end
  end

  // A write wins over the increment for that cycle
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      mtime_r <= '0;
    else if (wr_en && (offset == clint_mtime_offset_c))
      mtime_r <= cmd_i.data;
    else
      mtime_r <= mtime_r + 64'd1;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      resp_v_r <= 1'b0;
    else if (cmd_accept)
      resp_v_r <= 1'b1;
    else if (resp_ready_i)
      resp_v_r <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_accept)
    begin
      resp_r.msg_type <= cmd_i.msg_type;
      resp_r.addr     <= cmd_i.addr;
      resp_r.data     <= (cmd_i.msg_type == msg_write) ? '0 : rd_data;
    end
  end

  assign resp_o         = resp_r;
  assign resp_v_o       = resp_v_r;
  assign software_irq_o = msip_r;
  assign external_irq_o = plic_r;
  assign timer_irq_o    = (mtime_r >= mtimecmp_r);

  single_pending_a: assert property (@(posedge clk_i) disable iff (reset_i)
    (resp_v_o && !resp_ready_i) |=> (resp_v_o && $stable(resp_o)))
    else $error("clint changed or dropped a pending response");

endmodule

`default_nettype wire

/* logic/tile_io_loopback.sv */
/*
  Loopback responder for unmapped local devices
  - echoes type and address with zero data
*/
`timescale 1ns/1ps
`default_nettype none

module tile_io_loopback
  import tile_io_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  mem_msg_s cmd_i,
  input  logic     cmd_v_i,
  output logic     cmd_ready_o,
  output mem_msg_s resp_o,
  output logic     resp_v_o,
  input  logic     resp_ready_i
);

  msg_type_e resp_type_r;
  addr_u     resp_addr_r;
  logic      resp_v_r;
  logic      cmd_accept;

  assign cmd_ready_o = ~resp_v_r;
  assign cmd_accept  = cmd_v_i & cmd_ready_o;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      resp_v_r <= 1'b0;
    else if (cmd_accept)
      resp_v_r <= 1'b1;
    else if (resp_ready_i)
      resp_v_r <= 1'b0;
  end

  // Header only, the data beat is dropped
  always_ff @(posedge clk_i)
  begin
    if (cmd_accept)
    begin
      resp_type_r <= cmd_i.msg_type;
      resp_addr_r <= cmd_i.addr;
    end
  end

  assign resp_o.msg_type = resp_type_r;
  assign resp_o.addr     = resp_addr_r;
  assign resp_o.data     = '0;
  assign resp_v_o        = resp_v_r;

endmodule

`default_nettype wire

/* logic/tile_io_resp_arb.sv */
/*
  Response arbiter
  - fixed priority merge of four response streams
  - lowest sink index wins: mem, cfg, clint, loopback
*/
`timescale 1ns/1ps
`default_nettype none

module tile_io_resp_arb
  import tile_io_pkg::*;
(
  input  mem_msg_s [num_sinks_c-1:0] src_resp_i,
  input  logic     [num_sinks_c-1:0] src_v_i,
  output logic     [num_sinks_c-1:0] src_ready_o,
  output mem_msg_s                   resp_o,
  output logic                       resp_v_o,
  input  logic                       resp_ready_i
);

  sink_e                  grant;
  logic [num_sinks_c-1:0] grant_oh;

  // Scan from the top so the lowest valid index is left in grant
  always_comb
  begin
    grant = sink_loopback;
    for (int i = num_sinks_c - 1; i >= 0; i--)
    begin
      if (src_v_i[i])
        grant = sink_e'(i);
    end
  end

  // A source wins when no lower index is valid
  always_comb
  begin
    for (int i = 0; i < num_sinks_c; i++)
      grant_oh[i] = src_v_i[i] &&
                    ((src_v_i & ((num_sinks_c'(1) << i) - num_sinks_c'(1))) == '0);
  end

  // Ready only to the winner, only when downstream takes it
  assign src_ready_o = resp_ready_i ? grant_oh : '0;
  assign resp_v_o    = |src_v_i;
  assign resp_o      = src_resp_i[grant];

  always_comb
  begin
    grant_onehot_a: assert final ($onehot0(src_ready_o) &&
                                  (!(resp_v_o && resp_ready_i) || src_ready_o[grant]))
      else $error("response ready does not go to the one granted source");
  end

endmodule

`default_nettype wire

/* logic/tile_io.sv */
/*
  Tile I/O complex top level
  - command decoder and dispatch to four sinks
  - configuration block, CLINT slice and loopback responder
  - external memory command and response ports
  - response arbiter onto the outgoing response stream
*/
`timescale 1ns/1ps
`default_nettype none

module tile_io
  import tile_io_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,

  input  mem_msg_s io_cmd_i,
  input  logic     io_cmd_v_i,
  output logic     io_cmd_ready_o,

  output mem_msg_s io_resp_o,
  output logic     io_resp_v_o,
  input  logic     io_resp_ready_i,

  output mem_msg_s mem_cmd_o,
  output logic     mem_cmd_v_o,
  input  logic     mem_cmd_ready_i,

  input  mem_msg_s mem_resp_i,
  input  logic     mem_resp_v_i,
  output logic     mem_resp_ready_o,

  output cfg_bus_s cfg_bus_o,
  output logic     software_irq_o,
  output logic     timer_irq_o,
  output logic     external_irq_o
);

  logic     [num_sinks_c-1:0] sink_cmd_v;
  logic     [num_sinks_c-1:0] sink_cmd_ready;
  mem_msg_s [num_sinks_c-1:0] sink_resp;
  logic     [num_sinks_c-1:0] sink_resp_v;
  logic     [num_sinks_c-1:0] sink_resp_ready;

  logic     cfg_cmd_ready, clint_cmd_ready, lb_cmd_ready;
  mem_msg_s cfg_resp, clint_resp, lb_resp;
  logic     cfg_resp_v, clint_resp_v, lb_resp_v;

  // Sink vectors in sink_e order, memory at index 0
  assign sink_cmd_ready = {lb_cmd_ready, clint_cmd_ready, cfg_cmd_ready, mem_cmd_ready_i};
  assign sink_resp      = {lb_resp, clint_resp, cfg_resp, mem_resp_i};
  assign sink_resp_v    = {lb_resp_v, clint_resp_v, cfg_resp_v, mem_resp_v_i};

  // External memory port
  assign mem_cmd_o        = io_cmd_i;
  assign mem_cmd_v_o      = sink_cmd_v[sink_mem];
  assign mem_resp_ready_o = sink_resp_ready[sink_mem];

  tile_io_decode decode (
    .cmd_i        (io_cmd_i),
    .cmd_v_i      (io_cmd_v_i),
    .cmd_ready_o  (io_cmd_ready_o),
    .sink_v_o     (sink_cmd_v),
    .sink_ready_i (sink_cmd_ready)
  );

  tile_io_cfg cfg (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .cmd_i        (io_cmd_i),
    .cmd_v_i      (sink_cmd_v[sink_cfg]),
    .cmd_ready_o  (cfg_cmd_ready),
    .resp_o       (cfg_resp),
    .resp_v_o     (cfg_resp_v),
    .resp_ready_i (sink_resp_ready[sink_cfg]),
    .cfg_bus_o    (cfg_bus_o)
  );

  tile_io_clint clint (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .cmd_i          (io_cmd_i),
    .cmd_v_i        (sink_cmd_v[sink_clint]),
    .cmd_ready_o    (clint_cmd_ready),
    .resp_o         (clint_resp),
    .resp_v_o       (clint_resp_v),
    .resp_ready_i   (sink_resp_ready[sink_clint]),
    .software_irq_o (software_irq_o),
    .timer_irq_o    (timer_irq_o),
    .external_irq_o (external_irq_o)
  );

  tile_io_loopback loopback (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .cmd_i        (io_cmd_i),
    .cmd_v_i      (sink_cmd_v[sink_loopback]),
    .cmd_ready_o  (lb_cmd_ready),
    .resp_o       (lb_resp),
    .resp_v_o     (lb_resp_v),
    .resp_ready_i (sink_resp_ready[sink_loopback])
  );

  tile_io_resp_arb resp_arb (
    .src_resp_i   (sink_resp),
    .src_v_i      (sink_resp_v),
    .src_ready_o  (sink_resp_ready),
    .resp_o       (io_resp_o),
    .resp_v_o     (io_resp_v_o),
    .resp_ready_i (io_resp_ready_i)
  );

endmodule

`default_nettype wire

/* bench/tile_io_tb.sv */
/*
  Testbench for the tile I/O complex
  - clock, reset and command stimulus on the falling edge
  - memory model with random latency and random command ready
  - reference model of the register state and expected responses
  - response and memory command monitor
*/
`timescale 1ns/1ps
`default_nettype none

module tile_io_tb
  import tile_io_pkg::*;
;

  localparam logic [data_width_c-1:0] mem_pattern_c = 64'hA5A5_A5A5_5A5A_5A5A;
  localparam int wait_limit_c = 200;

  typedef struct packed {
    logic                       freeze;
    logic [core_id_width_c-1:0] core_id;
    logic [did_width_c-1:0]     host_did;
    logic                       msip;
    logic                       plic;
    logic [data_width_c-1:0]    mtimecmp;
  } shadow_s;

  logic     clk_i = 1'b0;
  logic     reset_i;
  mem_msg_s io_cmd_i;
  logic     io_cmd_v_i;
  logic     io_cmd_ready_o;
  mem_msg_s io_resp_o;
  logic     io_resp_v_o;
  logic     io_resp_ready_i = 1'b1;
  mem_msg_s mem_cmd_o;
  logic     mem_cmd_v_o;
  logic     mem_cmd_ready_i = 1'b0;
  mem_msg_s mem_resp_i = '0;
  logic     mem_resp_v_i = 1'b0;
  logic     mem_resp_ready_o;
  cfg_bus_s cfg_bus_o;
  logic     software_irq_o;
  logic     timer_irq_o;
  logic     external_irq_o;

  integer   seed = 48175;
  shadow_s  shadow;
  mem_msg_s expected;
  mem_msg_s cur_cmd;
  logic     expect_mem;
  logic     resp_backpressure = 1'b0;
  int       sent_count = 0;
  int       resp_count = 0;
  int       mon_mismatches = 0;
  int       chk_mismatches = 0;
  int       protocol_errors = 0;
  int       timeouts = 0;

  // Memory model storage, indexed by running command counts
  mem_msg_s mem_store [16];
  int       mem_cmd_count = 0;
  int       mem_issued_count = 0;
  int       mem_taken_count = 0;
  int       mem_delay = 0;

  tile_io UUT (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .io_cmd_i         (io_cmd_i),
    .io_cmd_v_i       (io_cmd_v_i),
    .io_cmd_ready_o   (io_cmd_ready_o),
    .io_resp_o        (io_resp_o),
    .io_resp_v_o      (io_resp_v_o),
    .io_resp_ready_i  (io_resp_ready_i),
    .mem_cmd_o        (mem_cmd_o),
    .mem_cmd_v_o      (mem_cmd_v_o),
    .mem_cmd_ready_i  (mem_cmd_ready_i),
    .mem_resp_i       (mem_resp_i),
    .mem_resp_v_i     (mem_resp_v_i),
    .mem_resp_ready_o (mem_resp_ready_o),
    .cfg_bus_o        (cfg_bus_o),
    .software_irq_o   (software_irq_o),
    .timer_irq_o      (timer_irq_o),
    .external_irq_o   (external_irq_o)
  );

  always #5 clk_i = ~clk_i;

  function automatic logic is_mem_addr(input addr_u a);
    return (a.paddr >= dram_base_c) || (a.fields.dev == dev_cache_c);
  endfunction

  function automatic logic [paddr_width_c-1:0] local_addr(input logic [7:0] tile,
      input logic [3:0] dev, input logic [offset_width_c-1:0] off);
    return {tile, dev, off};
  endfunction

  function automatic mem_msg_s make_cmd(input msg_type_e t,
      input logic [paddr_width_c-1:0] paddr, input logic [data_width_c-1:0] data);
    mem_msg_s m;
    m.msg_type   = t;
    m.addr.paddr = paddr;
    m.data       = data;
    return m;
  endfunction

  // Expected response from the memory map and the shadow registers
  function automatic mem_msg_s ref_resp(input mem_msg_s cmd, input shadow_s sh);
    mem_msg_s                  resp;
    logic [offset_width_c-1:0] off;
    logic [data_width_c-1:0]   rd;
    off = cmd.addr.fields.offset;
    rd  = '0;
    if (is_mem_addr(cmd.addr))
      rd = {32'h0, cmd.addr.paddr} ^ mem_pattern_c;
    else if (cmd.addr.fields.dev == dev_cfg_c)
    begin
      case (off)
        cfg_freeze_offset_c:   rd = 64'(sh.freeze);
        cfg_core_id_offset_c:  rd = 64'(sh.core_id);
        cfg_host_did_offset_c: rd = 64'(sh.host_did);
        default:               rd = '0;
      endcase
    end
    else if (cmd.addr.fields.dev == dev_clint_c)
    begin
      case (off)
        clint_msip_offset_c:     rd = 64'(sh.msip);
        clint_mtimecmp_offset_c: rd = sh.mtimecmp;
        clint_plic_offset_c:     rd = 64'(sh.plic);
        default:                 rd = '0;
      endcase
    end
    resp      = cmd;
    resp.data = (cmd.msg_type == msg_write) ? '0 : rd;
    return resp;
  endfunction

  function automatic shadow_s next_shadow(input shadow_s sh, input mem_msg_s cmd);
    shadow_s                   nx;
    logic [offset_width_c-1:0] off;
    nx  = sh;
    off = cmd.addr.fields.offset;
    if ((cmd.msg_type == msg_write) && !is_mem_addr(cmd.addr))
    begin
      if (cmd.addr.fields.dev == dev_cfg_c)
      begin
        case (off)
          cfg_freeze_offset_c:   nx.freeze   = cmd.data[0];
          cfg_core_id_offset_c:  nx.core_id  = cmd.data[core_id_width_c-1:0];
          cfg_host_did_offset_c: nx.host_did = cmd.data[did_width_c-1:0];
          default:               ;
        endcase
      end
      else if (cmd.addr.fields.dev == dev_clint_c)
      begin
        case (off)
          clint_msip_offset_c:     nx.msip     = cmd.data[0];
          clint_mtimecmp_offset_c: nx.mtimecmp = cmd.data;
          clint_plic_offset_c:     nx.plic     = cmd.data[0];
          default:                 ;
        endcase
      end
    end
    return nx;
  endfunction

  task automatic end_run();
    int total;
    total = mon_mismatches + chk_mismatches + protocol_errors + timeouts;
    $display("errors: %0d response mismatches, %0d output mismatches, %0d protocol, %0d timeouts",
             mon_mismatches, chk_mismatches, protocol_errors, timeouts);
    if (total == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  endtask

  task automatic give_up(input string what);
    timeouts++;
    $display("timeout at %0t: %s", $time, what);
    end_run();
  endtask

  task automatic check_value(input string what, input logic [63:0] got,
      input logic [63:0] exp);
    value_ok_a: assert (got === exp)
      else
      begin
        chk_mismatches++;
        $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
  endtask

  task automatic check_outputs(input logic check_timer, input logic timer_exp);
    cfg_bus_s bus_exp;
    bus_exp.freeze   = shadow.freeze;
    bus_exp.core_id  = shadow.core_id;
    bus_exp.host_did = shadow.host_did;
    check_value("cfg_bus_o", 64'(cfg_bus_o), 64'(bus_exp));
    check_value("software_irq_o", 64'(software_irq_o), 64'(shadow.msip));
    check_value("external_irq_o", 64'(external_irq_o), 64'(shadow.plic));
    if (check_timer)
      check_value("timer_irq_o", 64'(timer_irq_o), 64'(timer_exp));
  endtask

  // One command in flight, wait for acceptance then for its response
  task automatic send_cmd(input mem_msg_s cmd);
    int   cycles;
    int   mem_before;
    logic accepted;
    @(negedge clk_i);
    expected   = ref_resp(cmd, shadow);
    shadow     = next_shadow(shadow, cmd);
    cur_cmd    = cmd;
    expect_mem = is_mem_addr(cmd.addr);
    mem_before = mem_cmd_count;
    sent_count++;
    io_cmd_i   = cmd;
    io_cmd_v_i = 1'b1;
    accepted   = 1'b0;
    cycles     = 0;
    while (!accepted && (cycles < wait_limit_c))
    begin
      @(posedge clk_i);
      accepted = io_cmd_ready_o;
      cycles++;
    end
    @(negedge clk_i);
    io_cmd_v_i = 1'b0;
    if (!accepted)
      give_up("command was never accepted");
    else
    begin
      cycles = 0;
      while ((resp_count < sent_count) && (cycles < wait_limit_c))
      begin
        @(negedge clk_i);
        cycles++;
      end
      if (resp_count < sent_count)
        give_up("no response arrived for the command");
      else
        check_value("memory command count", 64'(mem_cmd_count - mem_before),
                    64'(expect_mem));
    end
  endtask

  task automatic random_cmd(output mem_msg_s cmd);
    int                        kind;
    int                        pick;
    logic [3:0]                dev;
    logic [offset_width_c-1:0] off;
    logic [7:0]                tile;
    kind = {$random(seed)} % 5;
    pick = {$random(seed)} % 4;
    off  = 20'($random(seed));
    tile = 8'($random(seed));
    dev  = 4'($random(seed));
    cmd.msg_type = (($random(seed) % 2) == 0) ? msg_read : msg_write;
    cmd.data     = {$random(seed), $random(seed)};
    case (kind)
      0: cmd.addr.paddr = dram_base_c | 32'($random(seed));
      1: cmd.addr.paddr = local_addr(tile, dev_cache_c, off);
      2: cmd.addr.paddr = local_addr(tile, dev_cfg_c, (pick == 0) ? cfg_freeze_offset_c
                            : (pick == 1) ? cfg_core_id_offset_c
                            : (pick == 2) ? cfg_host_did_offset_c : 20'h0_0020);
      // mtime left out, its value depends on the cycle
      3: cmd.addr.paddr = local_addr(tile, dev_clint_c, (pick == 0) ? clint_msip_offset_c
                            : (pick == 1) ? clint_mtimecmp_offset_c
                            : (pick == 2) ? clint_plic_offset_c : 20'h0_0100);
      default:
      begin
        if ((dev >= dev_cfg_c) && (dev <= dev_cache_c))
          dev = dev + 4'd3;
        cmd.addr.paddr = local_addr(tile, dev, off);
      end
    endcase
  endtask

  // Monitor on the rising edge
  always @(posedge clk_i)
  begin
    if (!reset_i && io_resp_v_o && io_resp_ready_i)
    begin
      resp_outstanding_a: assert (resp_count < sent_count)
        else
        begin
          protocol_errors++;
          $display("response at %0t arrived with no command outstanding", $time);
        end
      resp_match_a: assert (io_resp_o === expected)
        else
        begin
          mon_mismatches++;
          $display("mismatch at %0t: response %0d/%h/%h, expected %0d/%h/%h", $time,
                   io_resp_o.msg_type, io_resp_o.addr.paddr, io_resp_o.data,
                   expected.msg_type, expected.addr.paddr, expected.data);
        end
      resp_count++;
    end
    if (!reset_i && mem_cmd_v_o && mem_cmd_ready_i)
    begin
      mem_cmd_a: assert (expect_mem && (mem_cmd_o === cur_cmd))
        else
        begin
          mon_mismatches++;
          $display("mismatch at %0t: memory command %h, expected %h to memory %0b", $time,
                   mem_cmd_o, cur_cmd, expect_mem);
        end
      mem_store[mem_cmd_count[3:0]] = mem_cmd_o;
      mem_cmd_count++;
    end
    if (mem_resp_v_i && mem_resp_ready_o)
      mem_taken_count++;
  end

  // Memory model and response ready, driven on the falling edge
  always @(negedge clk_i)
  begin
    mem_cmd_ready_i = (($random(seed) % 4) != 0);
    io_resp_ready_i = resp_backpressure ? (($random(seed) % 3) != 0) : 1'b1;
    if (mem_resp_v_i && (mem_taken_count == mem_issued_count))
      mem_resp_v_i = 1'b0;
    if (!mem_resp_v_i && (mem_issued_count < mem_cmd_count))
    begin
      if (mem_delay > 0)
        mem_delay--;
      else
      begin
        mem_resp_i      = mem_store[mem_issued_count[3:0]];
        mem_resp_i.data = (mem_resp_i.msg_type == msg_write) ? '0
                          : ({32'h0, mem_resp_i.addr.paddr} ^ mem_pattern_c);
        mem_resp_v_i    = 1'b1;
        mem_issued_count++;
        mem_delay = {$random(seed)} % 6;
      end
    end
  end

  initial
  begin
    mem_msg_s                  cmd;
    logic [offset_width_c-1:0] cfg_offs [4];
    logic [paddr_width_c-1:0]  mem_addrs [4];
    logic [3:0]                lb_devs [4];
    cfg_offs  = '{cfg_freeze_offset_c, cfg_core_id_offset_c, cfg_host_did_offset_c, 20'h0_0020};
    mem_addrs = '{32'h8000_0040, 32'hFFFF_FFF8, local_addr(8'h01, dev_cache_c, 20'h0_0100),
                  local_addr(8'h7F, dev_cache_c, 20'hF_FFF8)};
    lb_devs   = '{4'd0, 4'd1, 4'd7, 4'd15};
    io_cmd_i   = '0;
    io_cmd_v_i = 1'b0;
    reset_i    = 1'b1;
    shadow          = '0;
    shadow.freeze   = 1'b1;
    shadow.mtimecmp = '1;
    repeat (5) @(negedge clk_i);
    reset_i = 1'b0;

    check_outputs(1'b1, 1'b0);
    send_cmd(make_cmd(msg_read, local_addr(8'h00, dev_cfg_c, cfg_freeze_offset_c), '0));

    send_cmd(make_cmd(msg_write, local_addr(8'h00, dev_cfg_c, cfg_freeze_offset_c), 64'h0));
    send_cmd(make_cmd(msg_write, local_addr(8'h00, dev_cfg_c, cfg_core_id_offset_c), 64'h3F5));
    send_cmd(make_cmd(msg_write, local_addr(8'h00, dev_cfg_c, cfg_host_did_offset_c),
                      64'hFFFF_000D));
    send_cmd(make_cmd(msg_write, local_addr(8'h00, dev_cfg_c, 20'h0_0020), 64'h77));
    for (int i = 0; i < 4; i++)
      send_cmd(make_cmd(msg_read, local_addr(8'h00, dev_cfg_c, cfg_offs[i]), '0));
    check_outputs(1'b1, 1'b0);

    send_cmd(make_cmd(msg_write, local_addr(8'h00, dev_clint_c, clint_msip_offset_c), 64'h1));
    check_outputs(1'b1, 1'b0);
    send_cmd(make_cmd(msg_write, local_addr(8'h00, dev_clint_c, clint_msip_offset_c), 64'h0));
    check_outputs(1'b1, 1'b0);
    send_cmd(make_cmd(msg_write, local_addr(8'h00, dev_clint_c, clint_plic_offset_c), 64'h1));
    check_outputs(1'b1, 1'b0);
    send_cmd(make_cmd(msg_write, local_addr(8'h00, dev_clint_c, clint_mtimecmp_offset_c), '0));
    check_outputs(1'b1, 1'b1);
    send_cmd(make_cmd(msg_read, local_addr(8'h00, dev_clint_c, clint_mtimecmp_offset_c), '0));
    send_cmd(make_cmd(msg_write, local_addr(8'h00, dev_clint_c, clint_mtimecmp_offset_c), '1));
    check_outputs(1'b1, 1'b0);
    send_cmd(make_cmd(msg_read, local_addr(8'h00, dev_clint_c, clint_plic_offset_c), '0));

    for (int i = 0; i < 4; i++)
    begin
      send_cmd(make_cmd(msg_read, mem_addrs[i], '0));
      send_cmd(make_cmd(msg_write, mem_addrs[i], 64'h0123_4567_89AB_CDEF ^ 64'(i)));
    end

    for (int i = 0; i < 4; i++)
    begin
      send_cmd(make_cmd(msg_read, local_addr(8'h02, lb_devs[i], 20'h0_0040), 64'h55));
      send_cmd(make_cmd(msg_write, local_addr(8'h02, lb_devs[i], 20'h0_0048), 64'hAA));
    end

    // Random mix under back-pressure
    resp_backpressure = 1'b1;
    repeat (200)
    begin
      @(posedge clk_i);
      random_cmd(cmd);
      send_cmd(cmd);
      check_outputs(1'b0, 1'b0);
    end
    resp_backpressure = 1'b0;
    end_run();
  end

endmodule

`default_nettype wire

/* tile_io.f */
logic/tile_io_pkg.sv
logic/tile_io_decode.sv
logic/tile_io_cfg.sv
logic/tile_io_clint.sv
logic/tile_io_loopback.sv
logic/tile_io_resp_arb.sv
logic/tile_io.sv
bench/tile_io_tb.sv

/* Makefile */
# Verilator build and run for the tile I/O complex

TOP := tile_io_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f tile_io.f

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q -F '*** PASSED ***' sim.log

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f tile_io.f

clean:
	rm -rf obj_dir sim.log
